/* verilog/dm_macros.svh */
/*
 * Debug module constants: bus and DMI widths, SRAM depth,
 * hart timing and debug register field positions
 */
`ifndef DM_MACROS_SVH
`define DM_MACROS_SVH

`define DM_DATA_W      32
`define DM_SBADDR_W    32
`define DM_DMIADDR_W   7
`define DM_SRAM_WORDS  256
`define DM_HALT_CYCLES 4
`define DM_RESET_PC    32'h0000_1000
`define DM_CSR_DPC     12'h7b1

// DMControl
`define DM_HALTREQ_BIT      31
`define DM_RESUMEREQ_BIT    30
`define DM_DMACTIVE_BIT     0
// DMStatus
`define DM_ALLRESUMEACK_BIT 17
`define DM_ALLHALTED_BIT    9
// AbstractCS
`define DM_CMDERR_HI        10
`define DM_CMDERR_LO        8
// Command
`define DM_TRANSFER_BIT     17
`define DM_WRITE_BIT        16
`define DM_REGNO_HI         15
`define DM_REGNO_LO         0
// SBCS
`define DM_SBBUSY_BIT       21
`define DM_SBREADONADDR_BIT 20
`define DM_SBACCESS_HI      19
`define DM_SBACCESS_LO      17
`define DM_SBAUTOINC_BIT    16
`define DM_SBREADONDATA_BIT 15
`define DM_SBERROR_HI       14
`define DM_SBERROR_LO       12

`endif

/* verilog/dm_pkg.sv */
/*
 * Shared debug module types: data, address and DMI vectors,
 * DMI and system bus request structs, register map and FSM states
 */
`include "dm_macros.svh"

package dm_pkg;

  typedef logic [`DM_DATA_W-1:0]    dm_word_t;
  typedef logic [`DM_SBADDR_W-1:0]  sb_addr_t;
  typedef logic [`DM_DMIADDR_W-1:0] dmi_addr_t;

  typedef enum logic [1:0] {
    DMI_NOP   = 2'd0,
    DMI_READ  = 2'd1,
    DMI_WRITE = 2'd2
  } dmi_op_e;

  // DMI register map, only the implemented subset
  typedef enum logic [`DM_DMIADDR_W-1:0] {
    DATA0      = 7'h04,
    DMCONTROL  = 7'h10,
    DMSTATUS   = 7'h11,
    ABSTRACTCS = 7'h16,
    COMMAND    = 7'h17,
    SBCS       = 7'h38,
    SBADDRESS0 = 7'h39,
    SBDATA0    = 7'h3c
  } dm_reg_e;

  typedef struct packed {
    dmi_addr_t addr;
    dmi_op_e   op;
    dm_word_t  data;
  } dmi_req_t;

  // One system bus word access
  typedef struct packed {
    sb_addr_t addr;
    logic     we;
    dm_word_t wdata;
  } sb_req_t;

  typedef enum logic [1:0] {
    HART_RUNNING,
    HART_HALTING,
    HART_HALTED
  } hart_state_e;

  typedef enum logic [1:0] {
    SBA_IDLE,
    SBA_REQ,
    SBA_RELEASE
  } sba_state_e;

endpackage

/* verilog/dm_regs.sv */
/*
 * DMI slave with the debug register file: DMControl, DMStatus, Data0,
 * AbstractCS, Command, SBCS, SBAddress0 and SBData0.
 * Starts system bus accesses and drives hart halt, resume and DPC writes.
 */
`timescale 1ns/1ps
`include "dm_macros.svh"

module dm_regs (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             dmi_req_i,
  input  dm_pkg::dmi_req_t dmi_req_data_i,
  output logic             dmi_ack_o,
  output dm_pkg::dm_word_t dmi_rdata_o,
  output logic             sb_start_o,
  output dm_pkg::sb_req_t  sb_req_o,
  input  logic             sb_busy_i,
  input  logic             sb_done_i,
  input  dm_pkg::dm_word_t sb_rdata_i,
  output logic             halt_req_o,
  output logic             resume_req_o,
  output logic             dpc_we_o,
  output dm_pkg::dm_word_t dpc_o,
  input  logic             halted_i,
  input  logic             resumeack_i
);

  logic             dmactive_q;
  dm_pkg::dm_word_t data0_q;
  logic [2:0]       cmderr_q;
  logic             sbreadonaddr_q;
  logic [2:0]       sbaccess_q;
  logic             sbautoinc_q;
  logic             sbreadondata_q;
  logic [2:0]       sberror_q;
  dm_pkg::sb_addr_t sbaddr_q;
  dm_pkg::dm_word_t sbdata_q;

  logic             dmi_fire;
  logic             dmi_wr;
  logic             cmd_is_dpc_wr;
  dm_pkg::dm_word_t rdata_d;
  logic             sb_trig;
  logic             sb_trig_we;
  dm_pkg::sb_addr_t sb_trig_addr;
  logic             sb_launch;

  // One access per rising req
  assign dmi_fire = dmi_req_i && !dmi_ack_o;
  assign dmi_wr   = dmi_fire && (dmi_req_data_i.op == dm_pkg::DMI_WRITE);
  assign dpc_o    = data0_q;

  assign cmd_is_dpc_wr = dmi_req_data_i.data[`DM_TRANSFER_BIT] &&
                         dmi_req_data_i.data[`DM_WRITE_BIT] &&
                         (dmi_req_data_i.data[`DM_REGNO_HI:`DM_REGNO_LO] ==
                          {4'h0, `DM_CSR_DPC});

  //////////////////////////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rdata_d = '0;
    if (dmactive_q) begin
      case (dmi_req_data_i.addr)
        dm_pkg::DMCONTROL: begin
          rdata_d[`DM_HALTREQ_BIT]   = halt_req_o;
          rdata_d[`DM_RESUMEREQ_BIT] = resume_req_o;
          rdata_d[`DM_DMACTIVE_BIT]  = dmactive_q;
        end
        dm_pkg::DMSTATUS: begin
          rdata_d[`DM_ALLRESUMEACK_BIT] = resumeack_i;
          rdata_d[`DM_ALLHALTED_BIT]    = halted_i;
        end
        dm_pkg::DATA0:      rdata_d = data0_q;
        dm_pkg::ABSTRACTCS: rdata_d[`DM_CMDERR_HI:`DM_CMDERR_LO] = cmderr_q;
        dm_pkg::SBCS: begin
          // Busy also covers the start pulse before the master picks it up
          rdata_d[`DM_SBBUSY_BIT]                   = sb_busy_i | sb_start_o;
          rdata_d[`DM_SBREADONADDR_BIT]             = sbreadonaddr_q;
          rdata_d[`DM_SBACCESS_HI:`DM_SBACCESS_LO]  = sbaccess_q;
          rdata_d[`DM_SBAUTOINC_BIT]                = sbautoinc_q;
          rdata_d[`DM_SBREADONDATA_BIT]             = sbreadondata_q;
          rdata_d[`DM_SBERROR_HI:`DM_SBERROR_LO]    = sberror_q;
        end
        dm_pkg::SBADDRESS0: rdata_d = sbaddr_q;
        dm_pkg::SBDATA0:    rdata_d = sbdata_q;
        default:            rdata_d = '0;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // System bus triggers
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    sb_trig      = 1'b0;
    sb_trig_we   = 1'b0;
    sb_trig_addr = sbaddr_q;
    if (dmi_fire && dmactive_q) begin
      if (dmi_req_data_i.op == dm_pkg::DMI_WRITE) begin
        if (dmi_req_data_i.addr == dm_pkg::SBADDRESS0) begin
          sb_trig      = sbreadonaddr_q;
          sb_trig_addr = dmi_req_data_i.data;
        end else if (dmi_req_data_i.addr == dm_pkg::SBDATA0) begin
          sb_trig    = 1'b1;
          sb_trig_we = 1'b1;
        end
      end else if (dmi_req_data_i.op == dm_pkg::DMI_READ &&
                   dmi_req_data_i.addr == dm_pkg::SBDATA0) begin
        sb_trig = sbreadondata_q;
      end
    end
  end

  // Dropped while an access is still in flight
  assign sb_launch = sb_trig && (sberror_q == 3'd0) && (sbaccess_q == 3'd2) &&
                     !sb_busy_i && !sb_start_o;

  always_ff @(posedge clk_i) begin
    if (sb_launch) begin
      sb_req_o.addr  <= sb_trig_addr;
      sb_req_o.we    <= sb_trig_we;
      sb_req_o.wdata <= dmi_req_data_i.data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Register updates and DMI handshake
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dmi_ack_o      <= 1'b0;
      dmi_rdata_o    <= '0;
      sb_start_o     <= 1'b0;
      dpc_we_o       <= 1'b0;
      halt_req_o     <= 1'b0;
      resume_req_o   <= 1'b0;
      dmactive_q     <= 1'b0;
      data0_q        <= '0;
      cmderr_q       <= 3'd0;
      sbreadonaddr_q <= 1'b0;
      sbaccess_q     <= 3'd0;
      sbautoinc_q    <= 1'b0;
      sbreadondata_q <= 1'b0;
      sberror_q      <= 3'd0;
      sbaddr_q       <= '0;
      sbdata_q       <= '0;
    end else begin
      sb_start_o <= sb_launch;
      dpc_we_o   <= 1'b0;

      if (dmi_fire) begin
        dmi_ack_o   <= 1'b1;
        dmi_rdata_o <= (dmi_req_data_i.op == dm_pkg::DMI_READ) ? rdata_d : '0;
      end else if (!dmi_req_i) begin
        dmi_ack_o <= 1'b0;
      end

      // Finished bus access
      if (sb_done_i) begin
        if (!sb_req_o.we) sbdata_q <= sb_rdata_i;
        if (sbautoinc_q) sbaddr_q <= sbaddr_q + 32'd4;
      end

      // Only word accesses are supported
      if (sb_trig && (sberror_q == 3'd0) && (sbaccess_q != 3'd2)) sberror_q <= 3'd4;

      if (dmi_wr && dmi_req_data_i.addr == dm_pkg::DMCONTROL) begin
        dmactive_q   <= dmi_req_data_i.data[`DM_DMACTIVE_BIT];
        halt_req_o   <= dmi_req_data_i.data[`DM_HALTREQ_BIT] &
                        dmi_req_data_i.data[`DM_DMACTIVE_BIT];
        resume_req_o <= dmi_req_data_i.data[`DM_RESUMEREQ_BIT] &
                        dmi_req_data_i.data[`DM_DMACTIVE_BIT];
      end

      if (dmi_wr && dmactive_q) begin
        case (dmi_req_data_i.addr)
          dm_pkg::DATA0: data0_q <= dmi_req_data_i.data;
          dm_pkg::ABSTRACTCS: begin
            cmderr_q <= cmderr_q & ~dmi_req_data_i.data[`DM_CMDERR_HI:`DM_CMDERR_LO];
          end
          dm_pkg::COMMAND: begin
            // Blocked until cmderr is cleared
            if (cmderr_q == 3'd0) begin
              if (!cmd_is_dpc_wr) begin
                cmderr_q <= 3'd2;
              end else if (!halted_i) begin
                cmderr_q <= 3'd4;
              end else begin
                dpc_we_o <= 1'b1;
              end
            end
          end
          dm_pkg::SBCS: begin
            sbreadonaddr_q <= dmi_req_data_i.data[`DM_SBREADONADDR_BIT];
            sbaccess_q     <= dmi_req_data_i.data[`DM_SBACCESS_HI:`DM_SBACCESS_LO];
            sbautoinc_q    <= dmi_req_data_i.data[`DM_SBAUTOINC_BIT];
            sbreadondata_q <= dmi_req_data_i.data[`DM_SBREADONDATA_BIT];
            sberror_q      <= sberror_q &
                              ~dmi_req_data_i.data[`DM_SBERROR_HI:`DM_SBERROR_LO];
          end
          dm_pkg::SBADDRESS0: sbaddr_q <= dmi_req_data_i.data;
          dm_pkg::SBDATA0:    sbdata_q <= dmi_req_data_i.data;
          default: ;
        endcase
      end
    end
  end

endmodule

/* verilog/dm_sba.sv */
/*
 * System bus master: takes one word request at a time and runs it
 * over the four-phase req/ack bus to the SRAM
 */
`timescale 1ns/1ps

module dm_sba (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             start_i,
  input  dm_pkg::sb_req_t  req_i,
  output logic             busy_o,
  output logic             done_o,
  output dm_pkg::dm_word_t rdata_o,
  output logic             bus_req_o,
  output dm_pkg::sb_req_t  bus_data_o,
  input  logic             bus_ack_i,
  input  dm_pkg::dm_word_t bus_rdata_i
);

  dm_pkg::sba_state_e state_q;

  assign busy_o = (state_q != dm_pkg::SBA_IDLE);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= dm_pkg::SBA_IDLE;
      bus_req_o <= 1'b0;
      done_o    <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        dm_pkg::SBA_IDLE: begin
          if (start_i) begin
            bus_req_o <= 1'b1;
            state_q   <= dm_pkg::SBA_REQ;
          end
        end
        dm_pkg::SBA_REQ: begin
          if (bus_ack_i) begin
            bus_req_o <= 1'b0;
            state_q   <= dm_pkg::SBA_RELEASE;
          end
        end
        dm_pkg::SBA_RELEASE: begin
          // Slave must drop ack before the next request
          if (!bus_ack_i) begin
            done_o  <= 1'b1;
            state_q <= dm_pkg::SBA_IDLE;
          end
        end
        default: state_q <= dm_pkg::SBA_IDLE;
      endcase
    end
  end

  // Request payload and read data
  always_ff @(posedge clk_i) begin
    if (state_q == dm_pkg::SBA_IDLE && start_i) bus_data_o <= req_i;
    if (state_q == dm_pkg::SBA_REQ && bus_ack_i) rdata_o <= bus_rdata_i;
  end

endmodule

/* verilog/dm_hart_ctrl.sv */
/*
 * Modelled hart run control: halt delay, resume from DPC,
 * DPC register and program counter
 */
`timescale 1ns/1ps
`include "dm_macros.svh"

module dm_hart_ctrl (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             halt_req_i,
  input  logic             resume_req_i,
  input  logic             dpc_we_i,
  input  dm_pkg::dm_word_t dpc_i,
  output logic             halted_o,
  output logic             resumeack_o,
  output logic             running_o,
  output dm_pkg::sb_addr_t pc_o
);

  localparam int CntW = $clog2(`DM_HALT_CYCLES + 1);

  dm_pkg::hart_state_e state_q;
  logic [CntW-1:0]     cnt_q;
  dm_pkg::dm_word_t    dpc_q;

  assign halted_o  = (state_q == dm_pkg::HART_HALTED);
  assign running_o = (state_q == dm_pkg::HART_RUNNING);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= dm_pkg::HART_RUNNING;
      cnt_q       <= '0;
      dpc_q       <= '0;
      pc_o        <= `DM_RESET_PC;
      resumeack_o <= 1'b0;
    end else begin
      if (dpc_we_i) dpc_q <= dpc_i;
      case (state_q)
        dm_pkg::HART_RUNNING: begin
          if (halt_req_i) begin
            cnt_q       <= CntW'(`DM_HALT_CYCLES - 1);
            resumeack_o <= 1'b0;
            state_q     <= dm_pkg::HART_HALTING;
          end
        end
        dm_pkg::HART_HALTING: begin
          // Counts down to the halted state
          if (cnt_q == '0) begin
            state_q <= dm_pkg::HART_HALTED;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        dm_pkg::HART_HALTED: begin
          // haltreq has priority over resumereq
          if (resume_req_i && !halt_req_i) begin
            pc_o        <= dpc_q;
            resumeack_o <= 1'b1;
            state_q     <= dm_pkg::HART_RUNNING;
          end
        end
        default: state_q <= dm_pkg::HART_RUNNING;
      endcase
    end
  end

endmodule

/* verilog/dm_sram.sv */
/*
 * Word-addressed single-port SRAM behind a four-phase bus slave port
 */
`timescale 1ns/1ps
`include "dm_macros.svh"

module dm_sram (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             bus_req_i,
  input  dm_pkg::sb_req_t  bus_data_i,
  output logic             bus_ack_o,
  output dm_pkg::dm_word_t bus_rdata_o
);

  localparam int IdxW = $clog2(`DM_SRAM_WORDS);

  dm_pkg::dm_word_t mem [`DM_SRAM_WORDS];
  logic [IdxW-1:0]  idx;

  // Byte address to word index, upper bits wrap
  assign idx = bus_data_i.addr[IdxW+1:2];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bus_ack_o <= 1'b0;
    end else begin
      bus_ack_o <= bus_req_i;
    end
  end

  // Access once, on the edge that raises ack
  always_ff @(posedge clk_i) begin
    if (bus_req_i && !bus_ack_o) begin
      if (bus_data_i.we) mem[idx] <= bus_data_i.wdata;
      bus_rdata_o <= mem[idx];
    end
  end

endmodule

/* verilog/dm_top.sv */
/*
 * Debug module top: DMI register file, system bus master,
 * SRAM and modelled hart control
 */
`timescale 1ns/1ps

module dm_top (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             dmi_req_i,
  input  dm_pkg::dmi_req_t dmi_req_data_i,
  output logic             dmi_ack_o,
  output dm_pkg::dm_word_t dmi_rdata_o,
  output logic             hart_running_o,
  output dm_pkg::sb_addr_t hart_pc_o
);

  // Register file to bus master
  logic             sb_start;
  logic             sb_busy;
  logic             sb_done;
  dm_pkg::sb_req_t  sb_req;
  dm_pkg::dm_word_t sb_rdata;

  // Bus master to SRAM
  logic             bus_req;
  logic             bus_ack;
  dm_pkg::sb_req_t  bus_data;
  dm_pkg::dm_word_t bus_rdata;

  // Hart control
  logic             halt_req;
  logic             resume_req;
  logic             dpc_we;
  dm_pkg::dm_word_t dpc;
  logic             halted;
  logic             resumeack;

  dm_regs u_regs (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .dmi_req_i      ( dmi_req_i      ),
    .dmi_req_data_i ( dmi_req_data_i ),
    .dmi_ack_o      ( dmi_ack_o      ),
    .dmi_rdata_o    ( dmi_rdata_o    ),
    .sb_start_o     ( sb_start       ),
    .sb_req_o       ( sb_req         ),
    .sb_busy_i      ( sb_busy        ),
    .sb_done_i      ( sb_done        ),
    .sb_rdata_i     ( sb_rdata       ),
    .halt_req_o     ( halt_req       ),
    .resume_req_o   ( resume_req     ),
    .dpc_we_o       ( dpc_we         ),
    .dpc_o          ( dpc            ),
    .halted_i       ( halted         ),
    .resumeack_i    ( resumeack      )
  );

  dm_sba u_sba (
    .clk_i       ( clk_i     ),
    .rst_i       ( rst_i     ),
    .start_i     ( sb_start  ),
    .req_i       ( sb_req    ),
    .busy_o      ( sb_busy   ),
    .done_o      ( sb_done   ),
    .rdata_o     ( sb_rdata  ),
    .bus_req_o   ( bus_req   ),
    .bus_data_o  ( bus_data  ),
    .bus_ack_i   ( bus_ack   ),
    .bus_rdata_i ( bus_rdata )
  );

  dm_sram u_sram (
    .clk_i       ( clk_i     ),
    .rst_i       ( rst_i     ),
    .bus_req_i   ( bus_req   ),
    .bus_data_i  ( bus_data  ),
    .bus_ack_o   ( bus_ack   ),
    .bus_rdata_o ( bus_rdata )
  );

  dm_hart_ctrl u_hart (
    .clk_i        ( clk_i          ),
    .rst_i        ( rst_i          ),
    .halt_req_i   ( halt_req       ),
    .resume_req_i ( resume_req     ),
    .dpc_we_i     ( dpc_we         ),
    .dpc_i        ( dpc            ),
    .halted_o     ( halted         ),
    .resumeack_o  ( resumeack      ),
    .running_o    ( hart_running_o ),
    .pc_o         ( hart_pc_o      )
  );

endmodule

/* testbench/tb_dm_top.sv */
/*
 * Debug module testbench: clock, reset, DMI handshake tasks,
 * reference model of SRAM, SBCS, DPC, cmderr and hart state,
 * compare tasks and the directed and random test sequence
 */
`timescale 1ns/1ps
`include "dm_macros.svh"

module tb_dm_top;

  localparam int ACK_TIMEOUT = 20;
  localparam int POLL_LIMIT  = 40;

  localparam dm_pkg::dm_word_t CTRL_ACTIVE  = 32'd1 << `DM_DMACTIVE_BIT;
  localparam dm_pkg::dm_word_t CTRL_HALT    = 32'd1 << `DM_HALTREQ_BIT;
  localparam dm_pkg::dm_word_t CTRL_RESUME  = 32'd1 << `DM_RESUMEREQ_BIT;
  localparam dm_pkg::dm_word_t STAT_HALTED  = 32'd1 << `DM_ALLHALTED_BIT;
  localparam dm_pkg::dm_word_t STAT_RESACK  = 32'd1 << `DM_ALLRESUMEACK_BIT;
  localparam dm_pkg::dm_word_t SBCS_BUSY    = 32'd1 << `DM_SBBUSY_BIT;

  logic             clk;
  logic             rst;
  logic             dmi_req;
  dm_pkg::dmi_req_t dmi_req_data;
  logic             dmi_ack;
  dm_pkg::dm_word_t dmi_rdata;
  logic             hart_running;
  dm_pkg::sb_addr_t hart_pc;

  integer seed;

  // Reference model state
  dm_pkg::dm_word_t model_mem [`DM_SRAM_WORDS];
  dm_pkg::dm_word_t model_data0;
  dm_pkg::dm_word_t model_dpc;
  dm_pkg::dm_word_t model_sbdata;
  dm_pkg::sb_addr_t model_sbaddr;
  logic [2:0]       model_cmderr;
  logic [2:0]       model_sberror;
  logic [2:0]       model_sbaccess;
  logic             model_roa;
  logic             model_rod;
  logic             model_autoinc;
  logic             model_halted;

  dm_top uut (
    .clk_i          ( clk          ),
    .rst_i          ( rst          ),
    .dmi_req_i      ( dmi_req      ),
    .dmi_req_data_i ( dmi_req_data ),
    .dmi_ack_o      ( dmi_ack      ),
    .dmi_rdata_o    ( dmi_rdata    ),
    .hart_running_o ( hart_running ),
    .hart_pc_o      ( hart_pc      )
  );

  always #10 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Error reporting and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t ns: %s", $time, what);
    stop_run();
  endtask

  task automatic check_word(input string name, input dm_pkg::dm_word_t got,
                            input dm_pkg::dm_word_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_pc(input string name, input dm_pkg::sb_addr_t got,
                          input dm_pkg::sb_addr_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // DMI driver
  //////////////////////////////////////////////////////////////////////

  // Four-phase access entered and left 1 ns after a rising edge
  task automatic dmi_access(input dm_pkg::dmi_op_e op, input dm_pkg::dmi_addr_t addr,
                            input dm_pkg::dm_word_t wdata,
                            output dm_pkg::dm_word_t rdata);
    int cycles;
    dmi_req_data.addr = addr;
    dmi_req_data.op   = op;
    dmi_req_data.data = wdata;
    dmi_req           = 1'b1;
    cycles = 0;
    while (!dmi_ack) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > ACK_TIMEOUT) report_timeout("DMI ack did not rise");
    end
    rdata   = dmi_rdata;
    dmi_req = 1'b0;
    cycles  = 0;
    while (dmi_ack) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > ACK_TIMEOUT) report_timeout("DMI ack did not fall");
    end
  endtask

  task automatic dmi_write(input dm_pkg::dmi_addr_t addr, input dm_pkg::dm_word_t data);
    dm_pkg::dm_word_t unused;
    dmi_access(dm_pkg::DMI_WRITE, addr, data, unused);
  endtask

  task automatic dmi_read(input dm_pkg::dmi_addr_t addr, output dm_pkg::dm_word_t data);
    dmi_access(dm_pkg::DMI_READ, addr, '0, data);
  endtask

  // Reads a register until the masked bits match
  task automatic poll_reg(input dm_pkg::dmi_addr_t addr, input dm_pkg::dm_word_t mask,
                          input dm_pkg::dm_word_t value, input string what);
    dm_pkg::dm_word_t rd;
    int polls;
    polls = 0;
    dmi_read(addr, rd);
    while ((rd & mask) != value) begin
      polls++;
      if (polls > POLL_LIMIT) report_timeout(what);
      dmi_read(addr, rd);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // System bus access through the model
  //////////////////////////////////////////////////////////////////////

  function automatic int mem_index(input dm_pkg::sb_addr_t addr);
    return int'((addr >> 2) % `DM_SRAM_WORDS);
  endfunction

  function automatic dm_pkg::dm_word_t sbcs_word(input logic roa, input logic [2:0] acc,
                                                 input logic ai, input logic rod,
                                                 input logic [2:0] err);
    dm_pkg::dm_word_t w;
    w = '0;
    w[`DM_SBREADONADDR_BIT]            = roa;
    w[`DM_SBACCESS_HI:`DM_SBACCESS_LO] = acc;
    w[`DM_SBAUTOINC_BIT]               = ai;
    w[`DM_SBREADONDATA_BIT]            = rod;
    w[`DM_SBERROR_HI:`DM_SBERROR_LO]   = err;
    return w;
  endfunction

  task automatic write_sbcs(input logic roa, input logic [2:0] acc, input logic ai,
                            input logic rod, input logic [2:0] err_clear);
    dmi_write(dm_pkg::SBCS, sbcs_word(roa, acc, ai, rod, err_clear));
    model_roa      = roa;
    model_sbaccess = acc;
    model_autoinc  = ai;
    model_rod      = rod;
    model_sberror  = model_sberror & ~err_clear;
  endtask

  task automatic check_sbcs();
    dm_pkg::dm_word_t rd;
    dmi_read(dm_pkg::SBCS, rd);
    check_word("sbcs", rd, sbcs_word(model_roa, model_sbaccess, model_autoinc,
                                     model_rod, model_sberror));
  endtask

  // Model one triggered access and wait for sbbusy low
  task automatic model_bus_access(input logic we);
    if (model_sberror == 3'd0 && model_sbaccess == 3'd2) begin
      if (we) model_mem[mem_index(model_sbaddr)] = model_sbdata;
      else model_sbdata = model_mem[mem_index(model_sbaddr)];
      if (model_autoinc) model_sbaddr = model_sbaddr + 32'd4;
    end else if (model_sberror == 3'd0) begin
      model_sberror = 3'd4;
    end
    poll_reg(dm_pkg::SBCS, SBCS_BUSY, '0, "sbbusy did not clear");
  endtask

  task automatic sbaddr_write(input dm_pkg::sb_addr_t addr);
    dmi_write(dm_pkg::SBADDRESS0, addr);
    model_sbaddr = addr;
    if (model_roa) model_bus_access(1'b0);
  endtask

  task automatic sbdata_write(input dm_pkg::dm_word_t data);
    dmi_write(dm_pkg::SBDATA0, data);
    model_sbdata = data;
    model_bus_access(1'b1);
  endtask

  task automatic sbdata_read_check();
    dm_pkg::dm_word_t rd;
    dmi_read(dm_pkg::SBDATA0, rd);
    check_word("sbdata0", rd, model_sbdata);
    if (model_rod) model_bus_access(1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Abstract command and hart run control
  //////////////////////////////////////////////////////////////////////

  function automatic dm_pkg::dm_word_t reg_write_cmd(input logic [15:0] regno);
    dm_pkg::dm_word_t w;
    w = '0;
    w[`DM_TRANSFER_BIT]              = 1'b1;
    w[`DM_WRITE_BIT]                 = 1'b1;
    w[`DM_REGNO_HI:`DM_REGNO_LO]     = regno;
    return w;
  endfunction

  task automatic check_cmderr();
    dm_pkg::dm_word_t rd;
    dm_pkg::dm_word_t exp;
    exp = '0;
    exp[`DM_CMDERR_HI:`DM_CMDERR_LO] = model_cmderr;
    dmi_read(dm_pkg::ABSTRACTCS, rd);
    check_word("abstractcs", rd, exp);
  endtask

  task automatic write_data0(input dm_pkg::dm_word_t data);
    dmi_write(dm_pkg::DATA0, data);
    model_data0 = data;
  endtask

  task automatic send_command(input dm_pkg::dm_word_t cmd);
    dmi_write(dm_pkg::COMMAND, cmd);
    if (model_cmderr == 3'd0) begin
      if (!(cmd[`DM_TRANSFER_BIT] && cmd[`DM_WRITE_BIT] &&
            cmd[`DM_REGNO_HI:`DM_REGNO_LO] == {4'h0, `DM_CSR_DPC})) begin
        model_cmderr = 3'd2;
      end else if (!model_halted) begin
        model_cmderr = 3'd4;
      end else begin
        model_dpc = model_data0;
      end
    end
    check_cmderr();
  endtask

  task automatic clear_cmderr();
    dmi_write(dm_pkg::ABSTRACTCS, 32'h7 << `DM_CMDERR_LO);
    model_cmderr = 3'd0;
    check_cmderr();
  endtask

  task automatic halt_hart();
    dmi_write(dm_pkg::DMCONTROL, CTRL_HALT | CTRL_ACTIVE);
    poll_reg(dm_pkg::DMSTATUS, STAT_HALTED | STAT_RESACK, STAT_HALTED,
             "hart did not halt");
    check_bit("hart_running_o", hart_running, 1'b0);
    model_halted = 1'b1;
  endtask

  // PC after resume comes from DPC
  task automatic resume_hart();
    dmi_write(dm_pkg::DMCONTROL, CTRL_RESUME | CTRL_ACTIVE);
    poll_reg(dm_pkg::DMSTATUS, STAT_HALTED | STAT_RESACK, STAT_RESACK,
             "hart did not resume");
    check_bit("hart_running_o", hart_running, 1'b1);
    check_pc("hart_pc_o", hart_pc, model_dpc);
    model_halted = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    dm_pkg::dm_word_t rd;
    dm_pkg::sb_addr_t base;
    logic [15:0]      regno;
    int               count;

    clk            = 1'b0;
    rst            = 1'b1;
    dmi_req        = 1'b0;
    dmi_req_data   = '0;
    seed           = 25616;
    model_data0    = '0;
    model_dpc      = '0;
    model_sbdata   = '0;
    model_sbaddr   = '0;
    model_cmderr   = 3'd0;
    model_sberror  = 3'd0;
    model_sbaccess = 3'd0;
    model_roa      = 1'b0;
    model_rod      = 1'b0;
    model_autoinc  = 1'b0;
    model_halted   = 1'b0;

    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    // Reset state and the dmactive gate
    check_bit("dmi_ack_o", dmi_ack, 1'b0);
    check_bit("hart_running_o", hart_running, 1'b1);
    check_pc("hart_pc_o", hart_pc, `DM_RESET_PC);
    dmi_write(dm_pkg::DATA0, $random(seed));
    dmi_read(dm_pkg::DATA0, rd);
    check_word("data0", rd, '0);
    dmi_read(dm_pkg::DMSTATUS, rd);
    check_word("dmstatus", rd, '0);
    dmi_read(dm_pkg::DMCONTROL, rd);
    check_word("dmcontrol", rd, '0);
    dmi_write(dm_pkg::DMCONTROL, CTRL_ACTIVE);
    dmi_read(dm_pkg::DMCONTROL, rd);
    check_word("dmcontrol", rd, CTRL_ACTIVE);
    dmi_read(dm_pkg::DATA0, rd);
    check_word("data0", rd, model_data0);

    // Registers keep their value but read as zero while inactive
    write_data0($random(seed));
    dmi_write(dm_pkg::DMCONTROL, '0);
    dmi_read(dm_pkg::DATA0, rd);
    check_word("data0", rd, '0);
    dmi_write(dm_pkg::DMCONTROL, CTRL_ACTIVE);
    dmi_read(dm_pkg::DATA0, rd);
    check_word("data0", rd, model_data0);

    // Burst write with auto-increment from a random base
    write_sbcs(1'b0, 3'd2, 1'b1, 1'b0, 3'd0);
    base  = $random(seed) & 32'hffff_fffc;
    count = 4 + int'($unsigned($random(seed)) % 9);
    sbaddr_write(base);
    for (int i = 0; i < count; i++) begin
      sbdata_write($random(seed));
    end
    dmi_read(dm_pkg::SBADDRESS0, rd);
    check_word("sbaddress0", rd, base + 32'(4 * count));

    // Readback through read-on-address and read-on-data
    write_sbcs(1'b1, 3'd2, 1'b1, 1'b1, 3'd0);
    sbaddr_write(base);
    for (int i = 0; i < count; i++) begin
      sbdata_read_check();
    end
    dmi_read(dm_pkg::SBADDRESS0, rd);
    check_word("sbaddress0", rd, model_sbaddr);
    check_sbcs();

    // Unsupported access size
    write_sbcs(1'b0, 3'd0, 1'b0, 1'b0, 3'd0);
    sbaddr_write(base);
    sbdata_write($random(seed));
    check_sbcs();
    write_sbcs(1'b1, 3'd2, 1'b0, 1'b0, 3'd7);
    check_sbcs();
    sbaddr_write(base);
    sbdata_read_check();

    // DPC command while the hart runs
    write_data0($random(seed));
    dmi_read(dm_pkg::DATA0, rd);
    check_word("data0", rd, model_data0);
    send_command(reg_write_cmd({4'h0, `DM_CSR_DPC}));
    clear_cmderr();
    halt_hart();
    resume_hart();

    // Halt, DPC write and resume
    halt_hart();
    write_data0($random(seed));
    send_command(reg_write_cmd({4'h0, `DM_CSR_DPC}));
    resume_hart();

    // Wrong register number while halted
    halt_hart();
    write_data0($random(seed));
    regno = 16'($random(seed));
    if (regno == {4'h0, `DM_CSR_DPC}) regno = regno ^ 16'h1;
    send_command(reg_write_cmd(regno));
    resume_hart();
    clear_cmderr();

    $display("test passed");
    $finish;
  end

endmodule

/* sim.f */
+incdir+verilog
verilog/dm_pkg.sv
verilog/dm_regs.sv
verilog/dm_sba.sv
verilog/dm_hart_ctrl.sv
verilog/dm_sram.sv
verilog/dm_top.sv
testbench/tb_dm_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the debug module testbench with Verilator.
# Exits non-zero when the build, the run or the result check fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_dm_top -f sim.f -o sim_dm
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/sim_dm > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qx "test passed" sim.log; then
  exit 0
fi

echo "Pass line not found in sim.log"
exit 1
